//--- filelist.f
common/exe_pkg.sv
design/exe_decode.sv
design/exe_alu.sv
design/exe_multiplier.sv
divider/exe_divider.sv
design/exe_control.sv
design/exe_result.sv
design/exe_stage.sv
tests/tb_exe_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_exe_stage \
   -f filelist.f -o sim_exe_stage > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

(./obj_dir/sim_exe_stage > sim.log 2>&1 || true) \
   && grep -qx '\*\* PASS \*\*' sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

//--- tests/tb_exe_stage.sv
/* Execute stage testbench: reference model, expected-value queues, assertions
 * ALU, multiply, divide, back-pressure and annul sequences */
`timescale 1ns/1ps
`default_nettype none

module tb_exe_stage;

   logic                          clk;
   logic                          reset;
   logic                          valid_i;
   exe_pkg::exe_op_e              opcode;
   logic [exe_pkg::XLEN-1:0]      op_a;
   logic [exe_pkg::XLEN-1:0]      op_b;
   logic                          so_i;
   logic                          stall_i;
   logic                          annul_i;
   logic                          stall_o;
   logic                          valid_o;
   logic [exe_pkg::XLEN-1:0]      result_o;
   logic [exe_pkg::CRF_W-1:0]     crf_o;
   logic                          ov_o;
   logic                          ca_o;

   logic [exe_pkg::XLEN-1:0]      exp_result_q[$];
   logic [exe_pkg::CRF_W+1:0]     exp_flags_q[$];  // {crf, ov, ca}
   int                            errors;
   int                            assert_errors;

   exe_stage exe_stage_inst (
      .clk      (clk),
      .reset    (reset),
      .valid_i  (valid_i),
      .opcode_i (opcode),
      .op_a_i   (op_a),
      .op_b_i   (op_b),
      .so_i     (so_i),
      .stall_i  (stall_i),
      .annul_i  (annul_i),
      .stall_o  (stall_o),
      .valid_o  (valid_o),
      .result_o (result_o),
      .crf_o    (crf_o),
      .ov_o     (ov_o),
      .ca_o     (ca_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                     // 40 ns period
   end

   ////////////////////
   // Output assertions

   hold_stable: assert property (@(posedge clk) disable iff (reset)
      (valid_o && stall_i && !annul_i) |=> (valid_o && $stable(result_o) && $stable(crf_o)))
      else begin
         assert_errors++;
         $display("CHECK FAILED t=%0t: outputs moved under stall_i", $time);
      end

   hold_stalls: assert property (@(posedge clk) disable iff (reset)
      (valid_o && stall_i) |-> stall_o)
      else begin
         assert_errors++;
         $display("CHECK FAILED t=%0t: stall_o low while output is held", $time);
      end

   annul_clears: assert property (@(posedge clk) disable iff (reset) annul_i |=> !valid_o)
      else begin
         assert_errors++;
         $display("CHECK FAILED t=%0t: valid_o set after annul", $time);
      end

   // LT/GT/EQ from result sign and zero
   crf_follows: assert property (@(posedge clk) disable iff (reset)
      valid_o |-> (crf_o[exe_pkg::CRF_LT] == result_o[exe_pkg::XLEN-1]) &&
                  (crf_o[exe_pkg::CRF_EQ] == (result_o == '0)) &&
                  (crf_o[exe_pkg::CRF_GT] == (!result_o[exe_pkg::XLEN-1] && result_o != '0)))
      else begin
         assert_errors++;
         $display("CHECK FAILED t=%0t: crf_o %b does not match result %h", $time, crf_o, result_o);
      end

   so_covers_ov: assert property (@(posedge clk) disable iff (reset)
      (valid_o && ov_o) |-> crf_o[exe_pkg::CRF_SO])
      else begin
         assert_errors++;
         $display("CHECK FAILED t=%0t: SO clear with ov_o set", $time);
      end

   ////////////////////
   // Reference model

   task automatic model_op(input exe_pkg::exe_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic so);
      logic [31:0] r;
      logic        ov;
      logic        ca;
      longint      sa;
      longint      sb;
      longint      wide;
      logic [63:0] uprod;
      sa    = $signed(a);
      sb    = $signed(b);
      r     = '0;
      ov    = 1'b0;
      ca    = 1'b0;
      uprod = 64'(a) * 64'(b);
      case (op)
         exe_pkg::OP_ADD: begin
            wide = sa + sb;
            r    = a + b;
            ca   = (64'(a) + 64'(b)) > 64'h0000_0000_ffff_ffff;
            ov   = wide != longint'($signed(r)); // Doesn't fit in 32 signed bits
         end
         exe_pkg::OP_SUB_BA: begin
            wide = sb - sa;
            r    = b - a;
            ca   = (b >= a);                     // No borrow
            ov   = wide != longint'($signed(r));
         end
         exe_pkg::OP_AND: r = a & b;
         exe_pkg::OP_OR:  r = a | b;
         exe_pkg::OP_XOR: r = a ^ b;
         exe_pkg::OP_NOR: r = ~(a | b);
         exe_pkg::OP_MUL_LO: begin
            wide = sa * sb;
            r    = wide[31:0];
            ov   = wide != longint'($signed(r));
         end
         exe_pkg::OP_MUL_HI: begin
            wide = sa * sb;
            r    = wide[63:32];
         end
         exe_pkg::OP_MUL_HIU: r = uprod[63:32];
         exe_pkg::OP_DIV: begin
            if (b == '0 || (a == 32'h8000_0000 && b == 32'hffff_ffff)) begin
               ov = 1'b1;
            end else begin
               wide = sa / sb;                   // Truncates toward zero
               r    = wide[31:0];
            end
         end
         exe_pkg::OP_DIVU: begin
            if (b == '0) ov = 1'b1;
            else r = a / b;
         end
         default: begin
         end
      endcase
      exp_result_q.push_back(r);
      exp_flags_q.push_back({r[31], !r[31] && (r != '0), r == '0, so | ov, ov, ca});
   endtask

   task automatic check_result(input logic was_valid);
      logic [31:0] exp_r;
      logic [5:0]  exp_f;
      exp_r = exp_result_q.pop_front();
      exp_f = exp_flags_q.pop_front();
      assert (!was_valid && valid_o) else begin
         errors++;
         $display("CHECK FAILED t=%0t: valid_o did not rise one cycle after acceptance", $time);
      end
      assert (result_o == exp_r) else begin
         errors++;
         $display("CHECK FAILED t=%0t: result_o %h, expected %h", $time, result_o, exp_r);
      end
      assert ({crf_o, ov_o, ca_o} == exp_f) else begin
         errors++;
         $display("CHECK FAILED t=%0t: crf/ov/ca %b, expected %b", $time,
                  {crf_o, ov_o, ca_o}, exp_f);
      end
   endtask

   ////////////////////
   // Stimulus

   // Called 2 ns after an edge, returns the same way with valid_o low again
   task automatic run_op(input exe_pkg::exe_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input int min_stalls, input int max_stalls, input int hold);
      int          stalls;
      int          i;
      logic        was_valid;
      logic [31:0] held;
      stalls  = 0;
      valid_i = 1'b1;
      opcode  = op;
      op_a    = a;
      op_b    = b;
      so_i    = 1'($urandom_range(0, 1));
      model_op(op, a, b, so_i);
      @(negedge clk);
      while (stall_o) begin                      // Inputs held while stalled
         stalls++;
         if (stalls > 200) begin
            $display("Timeout: stall_o never dropped for opcode %s", op.name());
            $display("** FAIL **");
            $finish;
         end
         @(negedge clk);
      end
      was_valid = valid_o;
      @(posedge clk);                            // Accepted here
      #2;
      valid_i = 1'b0;
      stall_i = (hold > 0);
      @(negedge clk);
      assert (stalls >= min_stalls && stalls <= max_stalls) else begin
         errors++;
         $display("CHECK FAILED t=%0t: stall_o high %0d cycles, expected %0d to %0d",
                  $time, stalls, min_stalls, max_stalls);
      end
      check_result(was_valid);
      held = result_o;
      for (i = 0; i < hold; i++) begin
         @(negedge clk);
         assert (valid_o && stall_o && result_o == held) else begin
            errors++;
            $display("CHECK FAILED t=%0t: output not held under stall_i", $time);
         end
      end
      if (hold > 0) begin
         @(posedge clk);
         #2;
         stall_i = 1'b0;
      end
      @(posedge clk);
      #2;
   endtask

   task automatic annul_divide();
      int i;
      valid_i = 1'b1;
      opcode  = exe_pkg::OP_DIV;
      op_a    = $urandom();
      op_b    = $urandom_range(1, 1000);
      for (i = 0; i < 5; i++) begin
         @(negedge clk);
         assert (stall_o && !valid_o) else begin
            errors++;
            $display("CHECK FAILED t=%0t: divide not stalling before annul", $time);
         end
      end
      @(posedge clk);
      #2;
      annul_i = 1'b1;                            // One-cycle flush, divide still presented
      @(posedge clk);
      #2;
      annul_i = 1'b0;
      valid_i = 1'b0;
      @(negedge clk);
      assert (!valid_o && !stall_o) else begin
         errors++;
         $display("CHECK FAILED t=%0t: stage not empty after annul", $time);
      end
      @(posedge clk);
      #2;
   endtask

   initial begin
      int n;
      void'($urandom(32'h5eda));
      errors        = 0;
      assert_errors = 0;
      reset         = 1'b1;
      valid_i       = 1'b0;
      opcode        = exe_pkg::OP_NOP;
      op_a          = '0;
      op_b          = '0;
      so_i          = 1'b0;
      stall_i       = 1'b0;
      annul_i       = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      assert (!valid_o && !stall_o && result_o == '0 && crf_o == '0 && !ov_o && !ca_o)
         else begin
            errors++;
            $display("CHECK FAILED t=%0t: outputs not cleared by reset", $time);
         end
      @(posedge clk);
      #2;

      for (n = 0; n < 24; n++)                   // Random ALU mix
         run_op(exe_pkg::exe_op_e'($urandom_range(1, 6)), $urandom(), $urandom(), 0, 0, 0);
      run_op(exe_pkg::OP_ADD, 32'h7fff_ffff, 32'h1, 0, 0, 0);
      run_op(exe_pkg::OP_SUB_BA, 32'h1, 32'h8000_0000, 0, 0, 0);
      run_op(exe_pkg::OP_ADD, 32'h0, 32'h0, 0, 0, 0);

      for (n = 0; n < 9; n++)
         run_op(exe_pkg::exe_op_e'($urandom_range(7, 9)), $urandom(), $urandom(), 1, 1, 0);
      run_op(exe_pkg::OP_MUL_LO, 32'hffff_ffff, 32'hffff_ffff, 1, 1, 0);
      run_op(exe_pkg::OP_MUL_HIU, 32'hffff_ffff, 32'hffff_ffff, 1, 1, 0);

      for (n = 0; n < 4; n++)
         run_op(exe_pkg::exe_op_e'($urandom_range(10, 11)), $urandom(),
                $urandom_range(1, 65535), exe_pkg::DIV_STEPS, 200, 0);
      run_op(exe_pkg::OP_DIV, $urandom(), 32'h0, exe_pkg::DIV_STEPS, 200, 0);
      run_op(exe_pkg::OP_DIVU, $urandom(), 32'h0, exe_pkg::DIV_STEPS, 200, 0);
      run_op(exe_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, exe_pkg::DIV_STEPS, 200, 0);
      run_op(exe_pkg::OP_DIV, 32'hffff_fff9, 32'h2, exe_pkg::DIV_STEPS, 200, 0);
      run_op(exe_pkg::OP_DIV, 32'h0001_2345, 32'hffff_fffd, exe_pkg::DIV_STEPS, 200, 0);

      // Back-pressure on the result register
      run_op(exe_pkg::OP_XOR, $urandom(), $urandom(), 0, 0, 4);
      run_op(exe_pkg::OP_MUL_HI, $urandom(), $urandom(), 1, 1, 3);

      annul_divide();
      run_op(exe_pkg::OP_ADD, $urandom(), $urandom(), 0, 0, 0);
      run_op(exe_pkg::OP_DIVU, $urandom(), $urandom_range(1, 255), exe_pkg::DIV_STEPS, 200, 0);

      repeat (2) @(posedge clk);
      $display("Errors: %0d value checks, %0d assertion checks", errors, assert_errors);
      if (errors == 0 && assert_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

//--- design/exe_stage.sv
/* Execute stage top: decode, ALU, multiplier, divider, FSM control, result */
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           valid_i,
   input  wire exe_pkg::exe_op_e         opcode_i,
   input  wire [exe_pkg::XLEN-1:0]       op_a_i,
   input  wire [exe_pkg::XLEN-1:0]       op_b_i,
   input  wire                           so_i,
   input  wire                           stall_i,
   input  wire                           annul_i,
   output logic                          stall_o,
   output logic                          valid_o,
   output logic [exe_pkg::XLEN-1:0]      result_o,
   output logic [exe_pkg::CRF_W-1:0]     crf_o,
   output logic                          ov_o,
   output logic                          ca_o
);

   exe_pkg::exe_unit_e       unit;
   exe_pkg::exe_state_e      next_state;
   logic                     is_signed;
   logic                     is_high;
   logic                     self_stall;
   logic                     enable_change;
   logic                     mul_enable;
   logic                     div_enable;
   logic                     div_done;
   logic                     accept;            // Instruction leaves this cycle
   logic [exe_pkg::XLEN-1:0] alu_result;
   logic                     alu_carry;
   logic                     alu_overflow;
   logic [exe_pkg::XLEN-1:0] mul_result;
   logic                     mul_overflow;
   logic [exe_pkg::XLEN-1:0] div_result;
   logic                     div_overflow;

   assign accept = enable_change && valid_i && !annul_i && !self_stall;

   exe_decode decode_inst (
      .opcode_i     (opcode_i),
      .unit_o       (unit),
      .signed_o     (is_signed),
      .high_o       (is_high),
      .next_state_o (next_state)
   );

   exe_alu alu_inst (
      .opcode_i   (opcode_i),
      .op_a_i     (op_a_i),
      .op_b_i     (op_b_i),
      .result_o   (alu_result),
      .carry_o    (alu_carry),
      .overflow_o (alu_overflow)
   );

   exe_multiplier multiplier_inst (
      .clk        (clk),
      .reset      (reset),
      .enable_i   (mul_enable),
      .signed_i   (is_signed),
      .high_i     (is_high),
      .op_a_i     (op_a_i),
      .op_b_i     (op_b_i),
      .product_o  (mul_result),
      .overflow_o (mul_overflow)
   );

   exe_divider divider_inst (
      .clk        (clk),
      .reset      (reset),
      .enable_i   (div_enable),
      .signed_i   (is_signed),
      .op_a_i     (op_a_i),
      .op_b_i     (op_b_i),
      .done_o     (div_done),
      .quotient_o (div_result),
      .overflow_o (div_overflow)
   );

   exe_control control_inst (
      .clk             (clk),
      .reset           (reset),
      .valid_i         (valid_i),
      .annul_i         (annul_i),
      .stall_i         (stall_i),
      .next_state_i    (next_state),
      .div_done_i      (div_done),
      .out_valid_i     (valid_o),
      .state_o         (),                // FSM state, probed for debug only
      .self_stall_o    (self_stall),
      .enable_change_o (enable_change),
      .mul_enable_o    (mul_enable),
      .div_enable_o    (div_enable),
      .stall_o         (stall_o)
   );

   exe_result result_inst (
      .clk             (clk),
      .reset           (reset),
      .enable_change_i (enable_change),
      .accept_i        (accept),
      .annul_i         (annul_i),
      .unit_i          (unit),
      .alu_result_i    (alu_result),
      .alu_carry_i     (alu_carry),
      .alu_overflow_i  (alu_overflow),
      .mul_result_i    (mul_result),
      .mul_overflow_i  (mul_overflow),
      .div_result_i    (div_result),
      .div_overflow_i  (div_overflow),
      .so_i            (so_i),
      .valid_o         (valid_o),
      .result_o        (result_o),
      .crf_o           (crf_o),
      .ov_o            (ov_o),
      .ca_o            (ca_o)
   );

endmodule

`default_nettype wire

//--- design/exe_result.sv
/* Result select, condition field (LT/GT/EQ/SO) and output registers */
`timescale 1ns/1ps
`default_nettype none

module exe_result (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           enable_change_i,
   input  wire                           accept_i,
   input  wire                           annul_i,
   input  wire exe_pkg::exe_unit_e       unit_i,
   input  wire [exe_pkg::XLEN-1:0]       alu_result_i,
   input  wire                           alu_carry_i,
   input  wire                           alu_overflow_i,
   input  wire [exe_pkg::XLEN-1:0]       mul_result_i,
   input  wire                           mul_overflow_i,
   input  wire [exe_pkg::XLEN-1:0]       div_result_i,
   input  wire                           div_overflow_i,
   input  wire                           so_i,
   output logic                          valid_o,
   output logic [exe_pkg::XLEN-1:0]      result_o,
   output logic [exe_pkg::CRF_W-1:0]     crf_o,
   output logic                          ov_o,
   output logic                          ca_o
);

   logic [exe_pkg::XLEN-1:0]  sel_result;
   logic                      sel_ov;
   logic                      sel_ca;
   logic [exe_pkg::CRF_W-1:0] crf_next;

   ////////////////////
   // Unit select

   always_comb begin
      sel_result = '0;
      sel_ov     = 1'b0;
      sel_ca     = 1'b0;                         // Only the ALU makes a carry
      case (unit_i)
         exe_pkg::UNIT_ALU: begin
            sel_result = alu_result_i;
            sel_ov     = alu_overflow_i;
            sel_ca     = alu_carry_i;
         end
         exe_pkg::UNIT_MUL: begin
            sel_result = mul_result_i;
            sel_ov     = mul_overflow_i;
         end
         exe_pkg::UNIT_DIV: begin
            sel_result = div_result_i;
            sel_ov     = div_overflow_i;
         end
         default: begin
         end
      endcase
   end

   // Condition field, zero when no unit produces a result
   always_comb begin
      crf_next = '0;
      if (unit_i != exe_pkg::UNIT_NONE) begin
         crf_next[exe_pkg::CRF_LT] = sel_result[exe_pkg::XLEN-1];
         crf_next[exe_pkg::CRF_GT] = !sel_result[exe_pkg::XLEN-1] && (sel_result != '0);
         crf_next[exe_pkg::CRF_EQ] = (sel_result == '0);
         crf_next[exe_pkg::CRF_SO] = so_i | sel_ov;   // Sticky summary overflow
      end
   end

   ////////////////////
   // Output registers

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_o  <= 1'b0;
         result_o <= '0;
         crf_o    <= '0;
         ov_o     <= 1'b0;
         ca_o     <= 1'b0;
      end else begin
         if (enable_change_i) begin              // Latch every open cycle
            result_o <= sel_result;
            crf_o    <= crf_next;
            ov_o     <= sel_ov;
            ca_o     <= sel_ca;
         end
         if (annul_i)
            valid_o <= 1'b0;                     // Flush, even when held
         else if (enable_change_i)
            valid_o <= accept_i;
      end
   end

endmodule

`default_nettype wire

//--- design/exe_control.sv
/* Multicycle FSM (IDLE/DIV/CONSUME), self-stall, enable_change and unit enables */
`timescale 1ns/1ps
`default_nettype none

module exe_control (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        valid_i,
   input  wire                        annul_i,
   input  wire                        stall_i,
   input  wire exe_pkg::exe_state_e   next_state_i,
   input  wire                        div_done_i,
   input  wire                        out_valid_i,
   output exe_pkg::exe_state_e        state_o,
   output logic                       self_stall_o,
   output logic                       enable_change_o,
   output logic                       mul_enable_o,
   output logic                       div_enable_o,
   output logic                       stall_o
);

   exe_pkg::exe_state_e state_r;
   logic                presented;              // Live instruction this cycle

   assign presented = valid_i && !annul_i;

   // Stall entering a multicycle op, and all through DIV. CONSUME lets go
   assign self_stall_o = presented &&
                         (((state_r == exe_pkg::ST_IDLE) && (next_state_i != exe_pkg::ST_IDLE)) ||
                          (state_r == exe_pkg::ST_DIV));

   // Output registers may change unless holding a valid result against stall
   assign enable_change_o = !out_valid_i || !stall_i;
   assign stall_o         = self_stall_o || !enable_change_o;

   assign mul_enable_o = presented && (state_r == exe_pkg::ST_IDLE);
   // Low in CONSUME so back-to-back divides restart the divider
   assign div_enable_o = presented && (next_state_i == exe_pkg::ST_DIV) &&
                         (state_r != exe_pkg::ST_CONSUME);

   ////////////////////
   // FSM, advances even while outputs are held

   always_ff @(posedge clk) begin
      if (reset || annul_i) begin
         state_r <= exe_pkg::ST_IDLE;
      end else if (presented) begin
         case (state_r)
            exe_pkg::ST_IDLE:    state_r <= next_state_i;
            exe_pkg::ST_DIV:     if (div_done_i) state_r <= exe_pkg::ST_CONSUME;
            exe_pkg::ST_CONSUME: if (enable_change_o) state_r <= exe_pkg::ST_IDLE;
            default:             state_r <= exe_pkg::ST_IDLE;
         endcase
      end
   end

   assign state_o = state_r;

endmodule

`default_nettype wire

//--- divider/exe_divider.sv
/* Radix-2 restoring divider, signed or unsigned, with one-cycle done pulse
 * Zero divisor and most-negative over minus one give 0 with overflow */
`timescale 1ns/1ps
`default_nettype none

module exe_divider (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           enable_i,
   input  wire                           signed_i,
   input  wire [exe_pkg::XLEN-1:0]       op_a_i,      // Dividend
   input  wire [exe_pkg::XLEN-1:0]       op_b_i,      // Divisor
   output logic                          done_o,
   output logic [exe_pkg::XLEN-1:0]      quotient_o,
   output logic                          overflow_o
);

   // Iteration state
   logic [exe_pkg::XLEN-1:0]      rem_r;
   logic [exe_pkg::XLEN-1:0]      quo_r;               // Dividend shifts out, quotient in
   logic [exe_pkg::XLEN-1:0]      dvs_r;
   logic                          neg_r;
   logic                          ovf_r;
   logic                          running_r;
   logic                          finished_r;
   logic                          done_r;
   logic [exe_pkg::DIV_CNT_W-1:0] step_r;
   logic [exe_pkg::XLEN-1:0]      quotient_r;
   logic                          overflow_r;

   logic                          neg_a;
   logic                          neg_b;
   logic [exe_pkg::XLEN-1:0]      mag_a;
   logic [exe_pkg::XLEN-1:0]      mag_b;
   logic [exe_pkg::XLEN:0]        shifted;
   logic [exe_pkg::XLEN:0]        trial;
   logic [exe_pkg::XLEN-1:0]      rem_next;
   logic [exe_pkg::XLEN-1:0]      quo_next;

   ////////////////////
   // Operand magnitudes

   assign neg_a = signed_i & op_a_i[exe_pkg::XLEN-1];
   assign neg_b = signed_i & op_b_i[exe_pkg::XLEN-1];
   assign mag_a = neg_a ? -op_a_i : op_a_i;
   assign mag_b = neg_b ? -op_b_i : op_b_i;

   ////////////////////
   // One shift-subtract step

   assign shifted = {rem_r, quo_r[exe_pkg::XLEN-1]};
   assign trial   = shifted - {1'b0, dvs_r};

   always_comb begin
      if (!trial[exe_pkg::XLEN]) begin                // Fits, keep difference
         rem_next = trial[exe_pkg::XLEN-1:0];
         quo_next = {quo_r[exe_pkg::XLEN-2:0], 1'b1};
      end else begin                                  // Restore
         rem_next = shifted[exe_pkg::XLEN-1:0];
         quo_next = {quo_r[exe_pkg::XLEN-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if (reset || !enable_i) begin                   // Back to start, result kept
         running_r  <= 1'b0;
         finished_r <= 1'b0;
         done_r     <= 1'b0;
         step_r     <= '0;
         if (reset) begin
            quotient_r <= '0;
            overflow_r <= 1'b0;
         end
      end else if (!running_r && !finished_r) begin  // Load cycle
         rem_r     <= '0;
         quo_r     <= mag_a;
         dvs_r     <= mag_b;
         neg_r     <= neg_a ^ neg_b;
         ovf_r     <= (op_b_i == '0) ||
                      (signed_i && op_a_i == {1'b1, {(exe_pkg::XLEN-1){1'b0}}} &&
                       op_b_i == '1);
         running_r <= 1'b1;
         step_r    <= '0;
      end else if (running_r) begin
         rem_r  <= rem_next;
         quo_r  <= quo_next;
         step_r <= step_r + 1'b1;
         if (step_r == exe_pkg::DIV_CNT_W'(exe_pkg::DIV_STEPS - 1)) begin
            running_r  <= 1'b0;
            finished_r <= 1'b1;
            done_r     <= 1'b1;
            quotient_r <= ovf_r ? '0 : (neg_r ? -quo_next : quo_next);
            overflow_r <= ovf_r;
         end
      end else begin
         done_r <= 1'b0;                              // Pulse only, then wait for enable drop
      end
   end

   assign done_o     = done_r;
   assign quotient_o = quotient_r;
   assign overflow_o = overflow_r;

endmodule

`default_nettype wire

//--- design/exe_multiplier.sv
/* Two-cycle 32x32 multiplier, registered product, low or high word out */
`timescale 1ns/1ps
`default_nettype none

module exe_multiplier (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           enable_i,
   input  wire                           signed_i,
   input  wire                           high_i,
   input  wire [exe_pkg::XLEN-1:0]       op_a_i,
   input  wire [exe_pkg::XLEN-1:0]       op_b_i,
   output logic [exe_pkg::XLEN-1:0]      product_o,
   output logic                          overflow_o
);

   logic signed [exe_pkg::XLEN:0]     ext_a;     // One extra bit, sign or zero
   logic signed [exe_pkg::XLEN:0]     ext_b;
   logic signed [2*exe_pkg::XLEN+1:0] full_prod;
   logic [2*exe_pkg::XLEN-1:0]        prod_r;
   logic                              high_r;

   assign ext_a     = {signed_i & op_a_i[exe_pkg::XLEN-1], op_a_i};
   assign ext_b     = {signed_i & op_b_i[exe_pkg::XLEN-1], op_b_i};
   assign full_prod = ext_a * ext_b;

   // First cycle captures, second cycle reads out
   always_ff @(posedge clk) begin
      if (reset) begin
         prod_r <= '0;
         high_r <= 1'b0;
      end else if (enable_i) begin
         prod_r <= full_prod[2*exe_pkg::XLEN-1:0];
         high_r <= high_i;
      end
   end

   assign product_o = high_r ? prod_r[2*exe_pkg::XLEN-1:exe_pkg::XLEN] :
                               prod_r[exe_pkg::XLEN-1:0];

   // Low word only: upper half must be pure sign extension
   assign overflow_o = !high_r &&
                       (prod_r[2*exe_pkg::XLEN-1:exe_pkg::XLEN] !=
                        {exe_pkg::XLEN{prod_r[exe_pkg::XLEN-1]}});

endmodule

`default_nettype wire

//--- design/exe_alu.sv
/* Single-cycle ALU: add, subtract B-A, logic ops, carry and overflow */
`timescale 1ns/1ps
`default_nettype none

module exe_alu (
   input  wire exe_pkg::exe_op_e         opcode_i,
   input  wire [exe_pkg::XLEN-1:0]       op_a_i,
   input  wire [exe_pkg::XLEN-1:0]       op_b_i,
   output logic [exe_pkg::XLEN-1:0]      result_o,
   output logic                          carry_o,
   output logic                          overflow_o
);

   logic [exe_pkg::XLEN:0] sum_ab;      // Carry out in MSB
   logic [exe_pkg::XLEN:0] diff_ba;     // B + ~A + 1, carry = no borrow
   logic                   ov_add;
   logic                   ov_sub;

   assign sum_ab  = {1'b0, op_a_i} + {1'b0, op_b_i};
   assign diff_ba = {1'b0, op_b_i} + {1'b0, ~op_a_i} + 1'b1;

   // Signed overflow from operand and result signs
   assign ov_add = (op_a_i[exe_pkg::XLEN-1] == op_b_i[exe_pkg::XLEN-1]) &&
                   (sum_ab[exe_pkg::XLEN-1] != op_a_i[exe_pkg::XLEN-1]);
   assign ov_sub = (op_b_i[exe_pkg::XLEN-1] != op_a_i[exe_pkg::XLEN-1]) &&
                   (diff_ba[exe_pkg::XLEN-1] != op_b_i[exe_pkg::XLEN-1]);

   always_comb begin
      result_o   = '0;
      carry_o    = 1'b0;                // Flags stay zero for logic ops
      overflow_o = 1'b0;
      case (opcode_i)
         exe_pkg::OP_ADD: begin
            result_o   = sum_ab[exe_pkg::XLEN-1:0];
            carry_o    = sum_ab[exe_pkg::XLEN];
            overflow_o = ov_add;
         end
         exe_pkg::OP_SUB_BA: begin
            result_o   = diff_ba[exe_pkg::XLEN-1:0];
            carry_o    = diff_ba[exe_pkg::XLEN];
            overflow_o = ov_sub;
         end
         exe_pkg::OP_AND: result_o = op_a_i & op_b_i;
         exe_pkg::OP_OR:  result_o = op_a_i | op_b_i;
         exe_pkg::OP_XOR: result_o = op_a_i ^ op_b_i;
         exe_pkg::OP_NOR: result_o = ~(op_a_i | op_b_i);
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

//--- design/exe_decode.sv
/* Opcode decode: result unit, signedness, high word select, multicycle state */
`timescale 1ns/1ps
`default_nettype none

module exe_decode (
   input  wire exe_pkg::exe_op_e     opcode_i,
   output exe_pkg::exe_unit_e        unit_o,
   output logic                      signed_o,
   output logic                      high_o,
   output exe_pkg::exe_state_e       next_state_o
);

   always_comb begin
      unit_o       = exe_pkg::UNIT_NONE;
      signed_o     = 1'b0;
      high_o       = 1'b0;
      next_state_o = exe_pkg::ST_IDLE;      // Single cycle unless told otherwise

      case (opcode_i)
         exe_pkg::OP_ADD, exe_pkg::OP_SUB_BA, exe_pkg::OP_AND,
         exe_pkg::OP_OR, exe_pkg::OP_XOR, exe_pkg::OP_NOR: begin
            unit_o = exe_pkg::UNIT_ALU;
         end
         // Multiplies always take two cycles, straight to CONSUME
         exe_pkg::OP_MUL_LO: begin
            unit_o       = exe_pkg::UNIT_MUL;
            signed_o     = 1'b1;            // Signed product for overflow check
            next_state_o = exe_pkg::ST_CONSUME;
         end
         exe_pkg::OP_MUL_HI: begin
            unit_o       = exe_pkg::UNIT_MUL;
            signed_o     = 1'b1;
            high_o       = 1'b1;
            next_state_o = exe_pkg::ST_CONSUME;
         end
         exe_pkg::OP_MUL_HIU: begin
            unit_o       = exe_pkg::UNIT_MUL;
            high_o       = 1'b1;
            next_state_o = exe_pkg::ST_CONSUME;
         end
         // Divides run until the divider says done
         exe_pkg::OP_DIV: begin
            unit_o       = exe_pkg::UNIT_DIV;
            signed_o     = 1'b1;
            next_state_o = exe_pkg::ST_DIV;
         end
         exe_pkg::OP_DIVU: begin
            unit_o       = exe_pkg::UNIT_DIV;
            next_state_o = exe_pkg::ST_DIV;
         end
         default: begin
         end                                // NOP, spare codes
      endcase
   end

endmodule

`default_nettype wire

//--- common/exe_pkg.sv
/* Execute stage shared definitions
 * Widths, condition field bit positions, opcode, unit and FSM state enums */
`default_nettype none

package exe_pkg;

   ////////////////////
   // Widths

   localparam int XLEN      = 32;               // Data word
   localparam int CRF_W     = 4;                // Condition field

   // Condition field bits
   localparam int CRF_LT    = 3;
   localparam int CRF_GT    = 2;
   localparam int CRF_EQ    = 1;
   localparam int CRF_SO    = 0;

   // Divider iteration count, one quotient bit per step
   localparam int DIV_STEPS = 32;
   localparam int DIV_CNT_W = $clog2(DIV_STEPS);

   ////////////////////
   // Enums

   typedef enum logic [3:0] {
      OP_NOP     = 4'h0,
      OP_ADD     = 4'h1,
      OP_SUB_BA  = 4'h2,                        // B minus A
      OP_AND     = 4'h3,
      OP_OR      = 4'h4,
      OP_XOR     = 4'h5,
      OP_NOR     = 4'h6,
      OP_MUL_LO  = 4'h7,
      OP_MUL_HI  = 4'h8,                        // Signed high word
      OP_MUL_HIU = 4'h9,                        // Unsigned high word
      OP_DIV     = 4'ha,
      OP_DIVU    = 4'hb
   } exe_op_e;

   // Which unit feeds the result register
   typedef enum logic [1:0] {
      UNIT_NONE = 2'h0,
      UNIT_ALU  = 2'h1,
      UNIT_MUL  = 2'h2,
      UNIT_DIV  = 2'h3
   } exe_unit_e;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'h0,
      ST_DIV     = 2'h2,                        // Waiting on divider
      ST_CONSUME = 2'h3                         // Result ready, take the instruction
   } exe_state_e;

endpackage

`default_nettype wire
